//--- source/spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// byte on MISO during the command byte of every frame
`define SPI_HEADER_BYTE 8'hA7

// implemented registers, addresses 0 .. count-1
`define SPI_REG_COUNT 16

// flops per pin in the input synchronizers
`define SPI_SYNC_STAGES 2

`endif

//--- source/spi_pkg.sv
package spi_pkg;

   // one byte on the wire, msb first
   typedef logic [7:0] spi_data_t;

   // received byte from the target
   typedef struct packed {
      logic      valid;   // one-cycle pulse
      logic      first;   // byte opened the frame
      spi_data_t data;
   } spi_rx_t;

   // byte offered back for shifting out
   typedef struct packed {
      logic      valid;
      spi_data_t data;
   } spi_tx_t;

   // command byte layout
   typedef struct packed {
      logic       write;  // 1 = write frame, 0 = read frame
      logic [6:0] addr;   // start address
   } spi_cmd_t;

endpackage

//--- source/bus_pkg.sv
package bus_pkg;

   // register address on the internal bus
   typedef logic [6:0] bus_addr_t;

   // request from the bridge
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;    // 1 = write
      bus_addr_t  adr;
      logic [7:0] dat;   // write data
   } bus_req_t;

   // response from the register bank
   typedef struct packed {
      logic       ack;   // single cycle
      logic [7:0] dat;   // read data, valid with ack
   } bus_rsp_t;

endpackage

//--- source/spi_target.sv
`timescale 1ns/1ns
`include "spi_cfg.svh"

module spi_target import spi_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    sck_i,      // raw pin
   input  logic    ssel_i,     // raw pin, active low
   input  logic    mosi_i,     // raw pin
   output logic    miso_o,
   output spi_rx_t rx_o,
   output logic    frame_o,
   input  spi_tx_t tx_i,
   output logic    tx_ready_o
);

   localparam int SYNC_N = `SPI_SYNC_STAGES;

   logic [SYNC_N-1:0] sck_q;
   logic [SYNC_N-1:0] ssel_q;
   logic [SYNC_N-1:0] mosi_q;
   logic              sck_s;
   logic              ssel_s;
   logic              mosi_s;
   logic              sck_d;      // previous synced sck
   logic              ssel_d;     // previous synced ssel
   logic              sck_rise;
   logic              sck_fall;
   logic              in_frame;
   logic              frame_start;
   logic [2:0]        bit_cnt;    // rising edges within the byte
   logic              byte_done;  // eighth bit just sampled
   logic              first_q;    // no byte seen yet in this frame
   spi_data_t         rx_shift;
   spi_data_t         tx_shift;

   // --------------------------------------------------
   // pin synchronizers and edge detect
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_q  <= '0;
         ssel_q <= '1;   // deselected
         mosi_q <= '0;
         sck_d  <= 1'b0;
         ssel_d <= 1'b1;
      end else begin
         sck_q  <= {sck_q[SYNC_N-2:0], sck_i};
         ssel_q <= {ssel_q[SYNC_N-2:0], ssel_i};
         mosi_q <= {mosi_q[SYNC_N-2:0], mosi_i};
         sck_d  <= sck_s;
         ssel_d <= ssel_s;
      end
   end

   assign sck_s       = sck_q[SYNC_N-1];
   assign ssel_s      = ssel_q[SYNC_N-1];
   assign mosi_s      = mosi_q[SYNC_N-1];
   assign sck_rise    = sck_s & ~sck_d;
   assign sck_fall    = ~sck_s & sck_d;
   assign in_frame    = ~ssel_s;
   assign frame_start = ~ssel_s & ssel_d;

   // byte boundary on the falling edge after the 8th rise
   assign tx_ready_o = sck_fall & in_frame & (bit_cnt == 3'd0);

   // --------------------------------------------------
   // receive side
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || !in_frame) begin   // partial byte dropped at frame end
         bit_cnt   <= 3'd0;
         byte_done <= 1'b0;
         first_q   <= 1'b0;
      end else begin
         byte_done <= sck_rise && (bit_cnt == 3'd7);
         if (sck_rise)
            bit_cnt <= bit_cnt + 3'd1;   // wraps after 8 bits
         if (frame_start)
            first_q <= 1'b1;
         else if (byte_done)
            first_q <= 1'b0;             // cleared as the command byte leaves
      end
   end

   always_ff @(posedge clk_i) begin
      if (sck_rise)
         rx_shift <= {rx_shift[6:0], mosi_s};   // msb first
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rx_o    <= '0;
         frame_o <= 1'b0;
      end else begin
         rx_o.valid <= byte_done;
         rx_o.first <= first_q;
         rx_o.data  <= rx_shift;
         frame_o    <= in_frame;
      end
   end

   // --------------------------------------------------
   // transmit side
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (frame_start)
         tx_shift <= `SPI_HEADER_BYTE;                 // header loaded unasked
      else if (tx_ready_o)
         tx_shift <= tx_i.valid ? tx_i.data : 8'h00;   // underrun sends zero
      else if (sck_fall && in_frame)
         tx_shift <= {tx_shift[6:0], 1'b0};
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         miso_o <= 1'b0;
      else
         miso_o <= frame_o ? tx_shift[7] : 1'b0;      // low between frames
   end

   // received bytes only come from inside a frame
   a_rx_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
      rx_o.valid |-> frame_o);

   // boundary strobe lasts one cycle
   a_tx_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      tx_ready_o |=> !tx_ready_o);

endmodule

//--- source/spi_bridge.sv
`timescale 1ns/1ns

module spi_bridge import spi_pkg::*, bus_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_i,
   input  spi_rx_t  rx_i,
   input  logic     frame_i,
   output spi_tx_t  tx_o,
   input  logic     tx_ready_i,
   output bus_req_t bus_o,
   input  bus_rsp_t bus_i
);

   typedef enum logic [2:0] {
      ST_IDLE,      // no frame
      ST_COMMAND,   // waiting for the command byte
      ST_WRITE,     // write frame, data bytes become bus writes
      ST_FETCH,     // read cycle in flight
      ST_HOLD       // prefetched byte waiting in tx
   } state_t;

   state_t    state_q;
   bus_addr_t addr_q;     // current register address
   bus_addr_t addr_nxt;
   spi_cmd_t  rx_cmd;
   logic      bus_done;
   logic      tx_take;

   assign rx_cmd   = spi_cmd_t'(rx_i.data);
   assign addr_nxt = addr_q + 1'b1;            // wraps at 127
   assign bus_done = bus_o.stb & bus_i.ack;
   assign tx_take  = tx_o.valid & tx_ready_i;

   // --------------------------------------------------
   // command decode and bus sequencing
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         addr_q  <= '0;
         bus_o   <= '0;
         tx_o    <= '0;
      end else begin
         if (bus_done) begin        // stb drops the cycle after ack
            bus_o.cyc <= 1'b0;
            bus_o.stb <= 1'b0;
         end

         case (state_q)
            ST_IDLE: begin
               tx_o.valid <= 1'b0;
               if (frame_i)
                  state_q <= ST_COMMAND;
            end

            ST_COMMAND: begin
               if (!frame_i) begin
                  state_q <= ST_IDLE;
               end else if (rx_i.valid && rx_i.first) begin
                  addr_q <= rx_cmd.addr;
                  if (rx_cmd.write) begin
                     state_q <= ST_WRITE;
                  end else begin
                     // first prefetch right away
                     bus_o   <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
                                  adr: rx_cmd.addr, dat: 8'h00};
                     state_q <= ST_FETCH;
                  end
               end
            end

            ST_WRITE: begin
               if (bus_done) begin
                  addr_q <= addr_nxt;
                  if (!frame_i)
                     state_q <= ST_IDLE;   // pending write finished first
               end else if (!bus_o.stb) begin
                  if (!frame_i)
                     state_q <= ST_IDLE;
                  else if (rx_i.valid)
                     bus_o <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                                adr: addr_q, dat: rx_i.data};
               end
            end

            ST_FETCH: begin
               if (bus_done) begin
                  if (frame_i) begin
                     tx_o    <= '{valid: 1'b1, data: bus_i.dat};
                     state_q <= ST_HOLD;
                  end else begin
                     state_q <= ST_IDLE;   // frame closed mid fetch
                  end
               end
            end

            ST_HOLD: begin
               if (!frame_i) begin
                  tx_o.valid <= 1'b0;
                  state_q    <= ST_IDLE;
               end else if (tx_take) begin
                  // byte handed over, fetch the next address
                  tx_o.valid <= 1'b0;
                  addr_q     <= addr_nxt;
                  bus_o      <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
                                  adr: addr_nxt, dat: 8'h00};
                  state_q    <= ST_FETCH;
               end
            end

            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // request frozen until the bank answers
   a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_o.stb && !bus_i.ack |=> $stable(bus_o));

   // sck pacing keeps the next byte behind the write ack
   a_no_rx_in_write: assert property (@(posedge clk_i) disable iff (rst_i)
      (state_q == ST_WRITE) && bus_o.stb |-> !rx_i.valid);

endmodule

//--- source/reg_bank.sv
`timescale 1ns/1ns
`include "spi_cfg.svh"

module reg_bank import bus_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_i,
   input  bus_req_t bus_i,
   output bus_rsp_t bus_o
);

   localparam int REG_N = `SPI_REG_COUNT;
   localparam int IDX_W = $clog2(REG_N);

   logic [7:0]       regs_q [REG_N];
   logic             strobe;   // new request, not yet acked
   logic             hit;      // address is implemented
   logic [IDX_W-1:0] idx;

   assign strobe = bus_i.cyc & bus_i.stb & ~bus_o.ack;
   assign hit    = (bus_i.adr < REG_N);
   assign idx    = bus_i.adr[IDX_W-1:0];

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i)
         regs_q <= '{default: 8'h00};
      else if (strobe && bus_i.we && hit)
         regs_q[idx] <= bus_i.dat;    // unmapped writes dropped
   end

   // response, one cycle after stb
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bus_o <= '0;
      end else begin
         bus_o.ack <= strobe;
         if (strobe && !bus_i.we)
            bus_o.dat <= hit ? regs_q[idx] : 8'h00;
      end
   end

   a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_o.ack |-> bus_i.cyc);

endmodule

//--- source/spi_reg_top.sv
`timescale 1ns/1ns

module spi_reg_top import spi_pkg::*, bus_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   input  logic sck_i,
   input  logic ssel_i,
   input  logic mosi_i,
   output logic miso_o
);

   spi_rx_t  rx;         // target -> bridge
   logic     frame;
   spi_tx_t  tx;         // bridge -> target
   logic     tx_ready;
   bus_req_t bus_req;    // bridge -> bank
   bus_rsp_t bus_rsp;

   spi_target u_target (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .sck_i      (sck_i),
      .ssel_i     (ssel_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .rx_o       (rx),
      .frame_o    (frame),
      .tx_i       (tx),
      .tx_ready_o (tx_ready)
   );

   spi_bridge u_bridge (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rx_i       (rx),
      .frame_i    (frame),
      .tx_o       (tx),
      .tx_ready_i (tx_ready),
      .bus_o      (bus_req),
      .bus_i      (bus_rsp)
   );

   reg_bank u_bank (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus_i (bus_req),
      .bus_o (bus_rsp)
   );

endmodule

//--- verif/spi_reg_tb.sv
`timescale 1ns/1ns
`include "spi_cfg.svh"

module spi_reg_tb import spi_pkg::*, bus_pkg::*; ();

   localparam int CLK_PERIOD = 100;              // ns
   localparam int HALF_SCK   = 8;                // clk cycles per sck phase
   localparam int GAP_CYCLES = 16;               // idle clocks between frames
   localparam int MAX_BYTES  = 16;               // longest frame in the vectors
   localparam int EDGE_LIMIT = 2 * CLK_PERIOD;   // ns allowed for one clock fall
   localparam int IDLE_LIMIT = 32;               // clock falls for miso to drop

   logic clk_i;
   logic rst_i;
   logic sck_i;
   logic ssel_i;   // active low
   logic mosi_i;
   logic miso_o;

   // current vector line
   string     vec_name;
   int        vec_count;              // bytes in the frame, command included
   int        vec_cut;                // bits clocked in the last byte
   spi_data_t vec_mosi [MAX_BYTES];
   spi_data_t vec_miso [MAX_BYTES];   // expected bytes after the header
   int        frames_run;

   spi_reg_top u_spi_reg_top (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .sck_i  (sck_i),
      .ssel_i (ssel_i),
      .mosi_i (mosi_i),
      .miso_o (miso_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // --------------------------------------------------
   // failure handling and waits
   // --------------------------------------------------
   task automatic stop_with_failure();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   // n falling clk edges, each one guarded
   task automatic wait_clocks(input int n, input string what);
      int i;
      for (i = 0; i < n; i++) begin
         fork
            @(negedge clk_i);
            begin
               #(EDGE_LIMIT);
               $display("Timeout: no clock edge while waiting for %s", what);
               stop_with_failure();
            end
         join_any
         disable fork;
      end
   endtask

   // miso is forced low once the target sees the frame closed
   task automatic wait_miso_idle(input string name);
      int n;
      n = 0;
      while (miso_o !== 1'b0) begin
         if (n == IDLE_LIMIT) begin
            $display("Timeout: miso did not return low after frame %s", name);
            stop_with_failure();
         end else begin
            wait_clocks(1, "miso to go low");
            n++;
         end
      end
   endtask

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_header(input string name, input spi_data_t act);
      if (act !== `SPI_HEADER_BYTE) begin
         $display("Error %s header byte expected %02h actual %02h",
                  name, `SPI_HEADER_BYTE, act);
         stop_with_failure();
      end
   endtask

   task automatic check_byte(input string name, input int idx,
                             input spi_data_t exp, input spi_data_t act);
      if (act !== exp) begin
         $display("Error %s byte %0d expected %02h actual %02h", name, idx, exp, act);
         stop_with_failure();
      end
   endtask

   // --------------------------------------------------
   // spi master, mode 0
   // --------------------------------------------------
   task automatic shift_byte(input spi_data_t tx, input int nbits, output spi_data_t rx);
      int k;
      rx = 8'h00;
      for (k = 0; k < nbits; k++) begin
         mosi_i = tx[7-k];                          // set up while sck low
         wait_clocks(HALF_SCK, "sck low phase");
         sck_i   = 1'b1;
         rx[7-k] = miso_o;                          // sample on the rise
         wait_clocks(HALF_SCK, "sck high phase");
         sck_i   = 1'b0;                            // target shifts here
      end
   endtask

   task automatic run_frame();
      spi_cmd_t  cmd;
      bus_addr_t start;
      spi_data_t got;
      int        b;
      int        nbits;
      cmd   = spi_cmd_t'(vec_mosi[0]);
      start = cmd.addr;
      $display("frame %s: %s from %0d, %0d bytes", vec_name,
               cmd.write ? "write" : "read", start, vec_count);
      ssel_i = 1'b0;
      for (b = 0; b < vec_count; b++) begin
         nbits = (b == vec_count - 1) ? vec_cut : 8;   // short last byte aborts
         shift_byte(vec_mosi[b], nbits, got);
         if (nbits == 8) begin
            if (b == 0)
               check_header(vec_name, got);
            else
               check_byte(vec_name, b, vec_miso[b-1], got);
         end
      end
      wait_clocks(HALF_SCK, "end of the last byte");
      ssel_i = 1'b1;
      wait_miso_idle(vec_name);
      wait_clocks(GAP_CYCLES, "gap between frames");
   endtask

   // --------------------------------------------------
   // vector reader
   // --------------------------------------------------
   task automatic read_frame(input int fd, output bit got_one);
      string            tok;
      logic [8*256-1:0] rest;   // remainder of a comment line
      int unsigned      val;
      int               n;
      int               i;
      got_one = 1'b0;
      n = $fscanf(fd, "%s", tok);
      while (n == 1 && tok[0] == "#") begin
         n = $fgets(rest, fd);
         n = $fscanf(fd, "%s", tok);
      end
      if (n == 1) begin
         vec_name = tok;
         n = $fscanf(fd, "%d %d", vec_count, vec_cut);
         if (n != 2 || vec_count < 1 || vec_count > MAX_BYTES
             || vec_cut < 1 || vec_cut > 8) begin
            $display("Vector line %s has a bad byte count or bit count", tok);
            stop_with_failure();
         end else begin
            for (i = 0; i < 2 * vec_count - 1; i++) begin
               n = $fscanf(fd, "%h", val);
               if (n != 1) begin
                  $display("Vector line %s is missing a byte", tok);
                  stop_with_failure();
               end else if (i < vec_count) begin
                  vec_mosi[i] = val[7:0];
               end else begin
                  vec_miso[i-vec_count] = val[7:0];
               end
            end
            got_one = 1'b1;
         end
      end
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      int fd;
      bit loaded;
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      sck_i      = 1'b0;   // mode 0 idle level
      ssel_i     = 1'b1;
      mosi_i     = 1'b0;
      frames_run = 0;
      wait_clocks(3, "end of reset");
      rst_i = 1'b0;
      wait_clocks(GAP_CYCLES, "settling after reset");

      fd = $fopen("verif/spi_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file verif/spi_vectors.txt");
         stop_with_failure();
      end else begin
         read_frame(fd, loaded);
         while (loaded) begin
            run_frame();
            frames_run++;
            read_frame(fd, loaded);
         end
         $fclose(fd);
         if (frames_run == 0) begin
            $display("The vector file holds no frames");
            stop_with_failure();
         end else begin
            $display("%0d frames checked", frames_run);
            $display("All tests passed");
            $finish;
         end
      end
   end

endmodule

//--- verif/spi_vectors.txt
# name  bytes  bits_in_last_byte  mosi bytes (hex)  miso bytes after the header (hex)
# a last byte shorter than 8 bits aborts the frame and its miso entry is ignored
read_after_reset  4 8  00 00 00 00     00 00 00
write_from_3      5 8  83 11 22 33 44  00 00 00 00
read_from_3       5 8  03 00 00 00 00  11 22 33 44
write_from_14     5 8  8e 5a a5 c3 3c  00 00 00 00
read_from_14      6 8  0e 00 00 00 00 00  5a a5 00 00 00
read_low_regs     5 8  00 00 00 00 00  00 00 00 11
write_wrap_127    3 8  ff 99 66        00 00
read_wrap_0       3 8  00 00 00        66 00
write_aborted     2 4  83 ee           00
read_after_abort  2 8  03 00           11

//--- vlog.f
+incdir+source
source/spi_pkg.sv
source/bus_pkg.sv
source/spi_target.sv
source/spi_bridge.sv
source/reg_bank.sv
source/spi_reg_top.sv
verif/spi_reg_tb.sv

//--- Bender.yml
package:
  name: spi_reg

sources:
  - include_dirs:
      - source
    files:
      - source/spi_pkg.sv
      - source/bus_pkg.sv
      - source/spi_target.sv
      - source/spi_bridge.sv
      - source/reg_bank.sv
      - source/spi_reg_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/spi_reg_tb.sv
